/* design/imuldiv_settings.svh */
/* widths and iteration count shared by the multiply/divide RTL
   include in any file that sizes operands, results or step counters */
`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// ------------------------------------------------------------
// operand and result sizing
// ------------------------------------------------------------

// width of one operand, the response word is twice this
`define IMULDIV_XLEN 32

// ------------------------------------------------------------
// iteration control
// ------------------------------------------------------------

// one shift-add or shift-subtract per step, one bit per step
`define IMULDIV_STEPS 32

// down-counter width, must hold IMULDIV_STEPS - 1
`define IMULDIV_CNT_W 5

`endif

/* design/imuldiv_msg_pkg.sv */
/* message formats of the multiply/divide unit: request function codes
   and the 64-bit response word, read as a product or a quotient/remainder pair */
`include "imuldiv_settings.svh"

package imuldiv_msg_pkg;

  // ------------------------------------------------------------
  // request function code
  // ------------------------------------------------------------

  // code 2'd3 is not defined and ends up in the divider as unsigned
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,  // signed multiply, full 64-bit product
    FN_DIV  = 2'd1,  // signed divide
    FN_DIVU = 2'd2   // unsigned divide
  } imuldiv_fn_e;

  // ------------------------------------------------------------
  // response word
  // ------------------------------------------------------------

  // divide view, remainder on top and quotient below
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quot;
  } div_pair_t;

  // same 64 bits, decoded per function
  typedef union packed {
    logic [2*`IMULDIV_XLEN-1:0] product;
    div_pair_t                  div;
  } imuldiv_resp_u;

endpackage

/* design/imuldiv_ctrl_pkg.sv */
/* controller states shared by the iterative multiplier and divider
   both step through idle, a fixed number of calc cycles, then done */
package imuldiv_ctrl_pkg;

  // ------------------------------------------------------------
  // iterative controller state
  // ------------------------------------------------------------

  // ST_IDLE  waits for a request, req_rdy is high only here
  // ST_CALC  one shift step per cycle until the counter hits zero
  // ST_DONE  resp_val held high until the response transfers
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_e;

  // 2'd3 is unreachable, the FSMs fall back to idle from it

endpackage

/* design/mul_ctrl_if.sv */
/* control and status bundle between the multiplier FSM and its datapath
   the controller connects through ctrl, the datapath through dpath */
`timescale 1ns/100ps

interface mul_ctrl_if;

  // ------------------------------------------------------------
  // control, FSM to datapath
  // ------------------------------------------------------------
  logic a_en;        // multiplicand register update
  logic b_en;        // multiplier register update
  logic load_sel;    // 0 loads fresh magnitudes, 1 takes shifted values
  logic acc_en;      // accumulator update
  logic acc_clear;   // accumulator to zero on load
  logic add_sel;     // add multiplicand into accumulator this step
  logic count_run;   // step counter decrements, otherwise presets
  logic sign_en;     // capture product sign from the raw operands
  logic negate_sel;  // present two's complement of the accumulator

  // ------------------------------------------------------------
  // status, datapath to FSM
  // ------------------------------------------------------------
  logic count_zero;  // last step is running
  logic b_lsb;       // current multiplier bit
  logic sign;        // stored product sign

  modport ctrl (
    output a_en, b_en, load_sel, acc_en, acc_clear, add_sel,
    output count_run, sign_en, negate_sel,
    input  count_zero, b_lsb, sign
  );

  modport dpath (
    input  a_en, b_en, load_sel, acc_en, acc_clear, add_sel,
    input  count_run, sign_en, negate_sel,
    output count_zero, b_lsb, sign
  );

endinterface

/* design/int_mul_dpath.sv */
/* signed multiplier datapath, shift-and-add on operand magnitudes
   steered cycle by cycle by int_mul_ctrl through the mul_ctrl_if bundle */
`timescale 1ns/100ps
`include "imuldiv_settings.svh"

module int_mul_dpath import imuldiv_msg_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`IMULDIV_XLEN-1:0] a,
  input  logic [`IMULDIV_XLEN-1:0] b,
  mul_ctrl_if.dpath                ctl,
  output imuldiv_resp_u            product
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int PW = 2 * XLEN;
  localparam int CNT_W = `IMULDIV_CNT_W;
  localparam logic [CNT_W-1:0] CNT_PRESET = CNT_W'(`IMULDIV_STEPS - 1);

  logic [XLEN-1:0]  mag_a;
  logic [XLEN-1:0]  mag_b;
  logic [PW-1:0]    a_reg;    // multiplicand, moves left
  logic [XLEN-1:0]  b_reg;    // multiplier, moves right
  logic [PW-1:0]    acc;
  logic             sign_reg;
  logic [CNT_W-1:0] cnt;

  // ------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------

  // the signed minimum maps to 2^31, still fits unsigned
  assign mag_a = a[XLEN-1] ? -a : a;
  assign mag_b = b[XLEN-1] ? -b : b;

  // ------------------------------------------------------------
  // shift registers, accumulator and sign
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (ctl.a_en) begin
      a_reg <= ctl.load_sel ? (a_reg << 1) : {{XLEN{1'b0}}, mag_a};
    end
    if (ctl.b_en) begin
      b_reg <= ctl.load_sel ? (b_reg >> 1) : mag_b;
    end
    // partial product only when the current multiplier bit is set
    if (ctl.acc_en) begin
      if (ctl.acc_clear) begin
        acc <= '0;
      end else if (ctl.add_sel) begin
        acc <= acc + a_reg;
      end
    end
    // result is negative when exactly one operand is
    if (ctl.sign_en) begin
      sign_reg <= a[XLEN-1] ^ b[XLEN-1];
    end
  end

  // step counter, sits at the preset whenever not running
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= CNT_PRESET;
    end else if (ctl.count_run) begin
      cnt <= cnt - 1'b1;
    end else begin
      cnt <= CNT_PRESET;
    end
  end

  // ------------------------------------------------------------
  // status and result
  // ------------------------------------------------------------
  assign ctl.count_zero = (cnt == '0);
  assign ctl.b_lsb = b_reg[0];
  assign ctl.sign = sign_reg;

  // sign fix-up on the way out, accumulator itself stays a magnitude
  assign product.product = ctl.negate_sel ? -acc : acc;

endmodule

/* design/int_mul_ctrl.sv */
/* multiplier control unit, idle/calc/done FSM over a val/rdy handshake
   drives datapath enables and selects through the mul_ctrl_if bundle */
`timescale 1ns/100ps

module int_mul_ctrl import imuldiv_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  output logic     resp_val,
  input  logic     resp_rdy,
  mul_ctrl_if.ctrl ctl
);

  iter_state_e state;
  iter_state_e state_next;

  // ------------------------------------------------------------
  // state register and transitions
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // req_rdy is high in idle, so val alone means transfer
      ST_IDLE: if (req_val) state_next = ST_CALC;
      // counter reads zero during the 32nd step
      ST_CALC: if (ctl.count_zero) state_next = ST_DONE;
      ST_DONE: if (resp_rdy) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // handshake and datapath control
  // ------------------------------------------------------------
  always_comb begin
    req_rdy = 1'b0;
    resp_val = 1'b0;
    ctl.a_en = 1'b0;
    ctl.b_en = 1'b0;
    ctl.load_sel = 1'b0;
    ctl.acc_en = 1'b0;
    ctl.acc_clear = 1'b0;
    ctl.add_sel = 1'b0;
    ctl.count_run = 1'b0;
    ctl.sign_en = 1'b0;
    ctl.negate_sel = 1'b0;
    case (state)
      ST_IDLE: begin
        req_rdy = 1'b1;
        // load magnitudes, clear accumulator, grab sign, all on accept
        ctl.a_en = req_val;
        ctl.b_en = req_val;
        ctl.acc_en = req_val;
        ctl.acc_clear = 1'b1;
        ctl.sign_en = req_val;
      end
      ST_CALC: begin
        // shift both operands every step
        ctl.a_en = 1'b1;
        ctl.b_en = 1'b1;
        ctl.load_sel = 1'b1;
        ctl.acc_en = 1'b1;
        ctl.add_sel = ctl.b_lsb;
        ctl.count_run = 1'b1;
      end
      ST_DONE: begin
        resp_val = 1'b1;
        ctl.negate_sel = ctl.sign;
      end
      default: ;
    endcase
  end

endmodule

/* design/int_div_iterative.sv */
/* iterative restoring divider, signed and unsigned, one bit per cycle
   returns remainder in the high half and quotient in the low half */
`timescale 1ns/100ps
`include "imuldiv_settings.svh"

module int_div_iterative
  import imuldiv_msg_pkg::*, imuldiv_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  imuldiv_fn_e              fn,
  input  logic [`IMULDIV_XLEN-1:0] a,
  input  logic [`IMULDIV_XLEN-1:0] b,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_resp_u            result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int CNT_W = `IMULDIV_CNT_W;
  localparam logic [CNT_W-1:0] CNT_PRESET = CNT_W'(`IMULDIV_STEPS - 1);

  iter_state_e      state;
  logic [CNT_W-1:0] cnt;
  logic [XLEN-1:0]  rem_reg;   // partial remainder
  logic [XLEN-1:0]  quo_reg;   // dividend shifts out, quotient bits shift in
  logic [XLEN-1:0]  dvs_reg;   // divisor magnitude
  logic             q_neg;
  logic             r_neg;
  logic             is_signed;
  logic             req_go;
  logic             resp_go;
  logic [XLEN-1:0]  mag_a;
  logic [XLEN-1:0]  mag_b;
  logic [XLEN:0]    partial;
  logic [XLEN:0]    diff;
  logic             fits;

  assign is_signed = (fn == FN_DIV);
  assign req_rdy = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);
  assign req_go = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // unsigned operands pass through untouched
  assign mag_a = (is_signed && a[XLEN-1]) ? -a : a;
  assign mag_b = (is_signed && b[XLEN-1]) ? -b : b;

  // ------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------

  // next dividend bit joins the remainder, one extra bit for the carry
  assign partial = {rem_reg, quo_reg[XLEN-1]};
  assign diff = partial - {1'b0, dvs_reg};
  assign fits = (partial >= {1'b0, dvs_reg});

  // ------------------------------------------------------------
  // FSM and step counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (req_go) state <= ST_CALC;
        ST_CALC: if (cnt == '0) state <= ST_DONE;
        ST_DONE: if (resp_go) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= CNT_PRESET;
    end else if (state == ST_CALC) begin
      cnt <= cnt - 1'b1;
    end else begin
      cnt <= CNT_PRESET;
    end
  end

  // ------------------------------------------------------------
  // operand load and iteration
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (req_go) begin
      rem_reg <= '0;
      quo_reg <= mag_a;
      dvs_reg <= mag_b;
      // quotient sign from both operands, skipped on a zero divisor
      q_neg <= is_signed && (a[XLEN-1] ^ b[XLEN-1]) && (b != '0);
      // remainder takes the dividend's sign
      r_neg <= is_signed && a[XLEN-1];
    end else if (state == ST_CALC) begin
      rem_reg <= fits ? diff[XLEN-1:0] : partial[XLEN-1:0];
      quo_reg <= {quo_reg[XLEN-2:0], fits};
    end
  end

  // zero divisor: every step fits, so quotient is all ones and the
  // remainder is |a|, which r_neg turns back into a
  // min / -1 lands on 2^31, negated that is min again
  always_comb begin
    result.div.rem = r_neg ? -rem_reg : rem_reg;
    result.div.quot = q_neg ? -quo_reg : quo_reg;
  end

endmodule

/* design/imuldiv_unit.sv */
/* top level of the multiply/divide unit, one operation in flight
   dispatches each request by function code and returns the selected response */
`timescale 1ns/100ps
`include "imuldiv_settings.svh"

module imuldiv_unit import imuldiv_msg_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  imuldiv_fn_e                req_fn,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output logic [2*`IMULDIV_XLEN-1:0] resp_result
);

  logic          is_mul;
  logic          busy;
  logic          mul_req_val;
  logic          mul_req_rdy;
  logic          mul_resp_val;
  logic          mul_resp_rdy;
  imuldiv_resp_u mul_product;
  logic          div_req_val;
  logic          div_req_rdy;
  logic          div_resp_val;
  logic          div_resp_rdy;
  imuldiv_resp_u div_result;
  imuldiv_resp_u resp_word;

  // ------------------------------------------------------------
  // request dispatch
  // ------------------------------------------------------------

  // anything that is not a multiply goes to the divider
  assign is_mul = (req_fn == FN_MUL);
  assign req_rdy = !busy && (is_mul ? mul_req_rdy : div_req_rdy);
  // the idle unit must not see a request while the other one works
  assign mul_req_val = req_val && !busy && is_mul;
  assign div_req_val = req_val && !busy && !is_mul;

  // set on accept, cleared when the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // units
  // ------------------------------------------------------------
  mul_ctrl_if mul_ctl ();

  int_mul_ctrl mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .ctl      (mul_ctl)
  );

  int_mul_dpath mul_dpath (
    .clk     (clk),
    .reset   (reset),
    .a       (req_a),
    .b       (req_b),
    .ctl     (mul_ctl),
    .product (mul_product)
  );

  int_div_iterative div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .fn       (req_fn),
    .a        (req_a),
    .b        (req_b),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .result   (div_result)
  );

  // ------------------------------------------------------------
  // response merge
  // ------------------------------------------------------------

  // at most one unit is in done at a time, rdy only to that one
  assign resp_val = mul_resp_val || div_resp_val;
  assign mul_resp_rdy = resp_rdy && mul_resp_val;
  assign div_resp_rdy = resp_rdy && div_resp_val;
  assign resp_word = mul_resp_val ? mul_product : div_result;
  assign resp_result = resp_word.product;

endmodule

/* test/tb_imuldiv.sv */
/* testbench for the multiply/divide unit, directed and random requests
   a reference model fills a queue of expected words, assertions check the response stream */
`timescale 1ns/100ps
`include "imuldiv_settings.svh"

module tb_imuldiv import imuldiv_msg_pkg::*; ();

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int PERIOD = 100;
  localparam int RESET_CYCLES = 16;
  localparam int N_DIRECTED = 23;
  localparam int N_RANDOM = 48;
  localparam int N_OPS = N_DIRECTED + N_RANDOM;
  // 33 cycles per operation plus back-pressure, with slack on top
  localparam int WATCHDOG_CYCLES = N_OPS * 40 + 1000;
  localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MAX_INT = {1'b0, {(XLEN-1){1'b1}}};

  logic                clk = 1'b0;
  logic                reset;
  logic                req_val;
  logic                req_rdy;
  imuldiv_fn_e         req_fn;
  logic [XLEN-1:0]     req_a;
  logic [XLEN-1:0]     req_b;
  logic                resp_val;
  logic                resp_rdy;
  logic [2*XLEN-1:0]   resp_result;

  // operand stream and back-pressure stream each run on their own variable
  integer              seed = 32'h165a;
  integer              bp_seed = 32'h165a;
  bit                  cur_random;
  logic [2*XLEN-1:0]   exp_q[$];
  int                  id_q[$];
  logic                exp_valid;
  logic [2*XLEN-1:0]   exp_head;
  int                  head_id;
  int unsigned         n_req;
  int unsigned         n_resp;
  int unsigned         n_sent = 0;

  imuldiv_unit DUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #(PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // full signed product, both operands sign-extended first
  function automatic logic [2*XLEN-1:0] mul_ref(input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    sa = {{XLEN{a[XLEN-1]}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    return sa * sb;
  endfunction

  // remainder on top, quotient below
  // SV division truncates toward zero and % follows the dividend's sign
  function automatic logic [2*XLEN-1:0] div_ref(input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b,
                                                input bit is_signed);
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (is_signed && a == MIN_INT && b == '1) begin
      q = MIN_INT;
      r = '0;
    end else if (is_signed) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  function automatic logic [2*XLEN-1:0] expected_result(input imuldiv_fn_e fn,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
    case (fn)
      FN_MUL:  return mul_ref(a, b);
      FN_DIV:  return div_ref(a, b, 1'b1);
      default: return div_ref(a, b, 1'b0);
    endcase
  endfunction

  // id is the function code, plus 3 for random requests
  function automatic string test_name(input int id);
    case (id)
      0:       return "mul_directed";
      1:       return "div_directed";
      2:       return "divu_directed";
      3:       return "mul_random";
      4:       return "div_random";
      default: return "divu_random";
    endcase
  endfunction

  // ------------------------------------------------------------
  // error reporting
  // ------------------------------------------------------------
  task automatic halt_with_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [2*XLEN-1:0] exp,
                                 input logic [2*XLEN-1:0] act);
    halt_with_failure($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
  endtask

  // ------------------------------------------------------------
  // transfer bookkeeping, one entry per accepted request
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      n_req = 0;
      n_resp = 0;
      exp_q.delete();
      id_q.delete();
      exp_valid <= 1'b0;
    end else begin
      if (resp_val && resp_rdy) begin
        n_resp = n_resp + 1;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
          void'(id_q.pop_front());
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        id_q.push_back(int'(req_fn) + (cur_random ? 3 : 0));
        n_req = n_req + 1;
      end
      exp_valid <= (exp_q.size() != 0);
      if (exp_q.size() != 0) begin
        exp_head <= exp_q[0];
        head_id <= id_q[0];
      end
    end
  end

  // ------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------
  a_reset_state: assert property (@(posedge clk) $past(reset) |-> (!resp_val && req_rdy))
    else halt_with_failure("after reset resp_val is high or req_rdy is low");

  a_no_stray: assert property (@(posedge clk) disable iff (reset) resp_val |-> exp_valid)
    else halt_with_failure("resp_val raised with no request outstanding");

  a_value: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && exp_valid) |-> (resp_result == exp_head))
    else report_mismatch(test_name($sampled(head_id)), $sampled(exp_head),
                         $sampled(resp_result));

  // only one operation in flight, no accept until the response leaves
  a_one_in_flight: assert property (@(posedge clk) disable iff (reset) exp_valid |-> !req_rdy)
    else halt_with_failure("req_rdy high while an operation is still in flight");

  a_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else halt_with_failure("response dropped or changed while resp_rdy was low");

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // hold the request until an accepting edge has been counted
  task automatic send_op(input imuldiv_fn_e fn, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input bit random_op);
    int unsigned start;
    start = n_req;
    req_val = 1'b1;
    req_fn = fn;
    req_a = a;
    req_b = b;
    cur_random = random_op;
    n_sent = n_sent + 1;
    do begin
      @(negedge clk);
    end while (n_req == start);
    req_val = 1'b0;
  endtask

  task automatic send_random_op();
    int pick;
    imuldiv_fn_e fn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    pick = $unsigned($random(seed)) % 3;
    case (pick)
      0:       fn = FN_MUL;
      1:       fn = FN_DIV;
      default: fn = FN_DIVU;
    endcase
    a = $random(seed);
    b = $random(seed);
    // small operands now and then, so quotients and remainders both matter
    if (($random(seed) & 3) == 0) b = b & 32'h0000_00ff;
    if (($random(seed) & 7) == 0) a = a & 32'h0000_0fff;
    send_op(fn, a, b, 1'b1);
  endtask

  // random low stretches on resp_rdy
  initial begin
    resp_rdy = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    forever begin
      resp_rdy = 1'b0;
      repeat ($unsigned($random(bp_seed)) % 4) @(negedge clk);
      resp_rdy = 1'b1;
      repeat ($unsigned($random(bp_seed)) % 4 + 1) @(negedge clk);
    end
  end

  initial begin
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = FN_MUL;
    req_a = '0;
    req_b = '0;
    cur_random = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // signed multiply corners
    send_op(FN_MUL, 32'd0, 32'd12345, 1'b0);
    send_op(FN_MUL, 32'd1, 32'hffff_ffff, 1'b0);
    send_op(FN_MUL, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    send_op(FN_MUL, MIN_INT, 32'd1, 1'b0);
    send_op(FN_MUL, MIN_INT, MIN_INT, 1'b0);
    send_op(FN_MUL, MIN_INT, 32'hffff_ffff, 1'b0);
    send_op(FN_MUL, -32'd7, 32'd9, 1'b0);
    send_op(FN_MUL, 32'd123456, -32'd654321, 1'b0);
    send_op(FN_MUL, MAX_INT, MAX_INT, 1'b0);

    // signed divide, all four sign combinations then the special cases
    send_op(FN_DIV, 32'd100, 32'd7, 1'b0);
    send_op(FN_DIV, -32'd100, 32'd7, 1'b0);
    send_op(FN_DIV, 32'd100, -32'd7, 1'b0);
    send_op(FN_DIV, -32'd100, -32'd7, 1'b0);
    send_op(FN_DIV, 32'd5, 32'd0, 1'b0);
    send_op(FN_DIV, -32'd5, 32'd0, 1'b0);
    send_op(FN_DIV, MIN_INT, 32'hffff_ffff, 1'b0);
    send_op(FN_DIV, MIN_INT, 32'd1, 1'b0);
    send_op(FN_DIV, 32'd0, 32'd3, 1'b0);

    // unsigned divide
    send_op(FN_DIVU, 32'd100, 32'd7, 1'b0);
    send_op(FN_DIVU, 32'hffff_ffff, 32'd3, 1'b0);
    send_op(FN_DIVU, 32'd5, 32'd0, 1'b0);
    send_op(FN_DIVU, MIN_INT, 32'hffff_ffff, 1'b0);
    send_op(FN_DIVU, 32'd7, 32'd100, 1'b0);

    // random mix of all three functions
    repeat (N_RANDOM) send_random_op();

    while (n_resp < n_sent) @(negedge clk);
    repeat (4) @(negedge clk);
    if (n_req == n_sent && n_resp == n_sent && exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      halt_with_failure($sformatf("%0d requests sent, %0d accepted, %0d responses",
                                  n_sent, n_req, n_resp));
    end
  end

  // watchdog
  initial begin
    #(PERIOD * (RESET_CYCLES + WATCHDOG_CYCLES));
    halt_with_failure("timeout, responses stopped arriving");
  end

endmodule

/* list.f */
+incdir+design
design/imuldiv_msg_pkg.sv
design/imuldiv_ctrl_pkg.sv
design/mul_ctrl_if.sv
design/int_mul_dpath.sv
design/int_mul_ctrl.sv
design/int_div_iterative.sv
design/imuldiv_unit.sv
test/tb_imuldiv.sv

/* run.sh */
#!/bin/sh
# build and run the multiply/divide testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_imuldiv -f list.f -o tb_imuldiv > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_imuldiv > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
